//--- all.f
src/filter_pkg.sv
src/r2_compute.sv
src/filter_buffer.sv
src/filter_logic.sv
src/filter_arbiter.sv
src/filter_bank.sv
tests/tb_clock.sv
tests/filter_checker.sv
tests/filter_bank_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the filter bank testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module filter_bank_tb -f all.f -o filter_bank_sim > sim.log 2>&1 &&
./obj_dir/filter_bank_sim >> sim.log 2>&1 ||
echo "TEST RESULT: FAIL" >> sim.log

cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
exit 0

//--- src/filter_arbiter.sv
`default_nettype none

module filter_arbiter (
	input logic clk,
	input logic rst,
	input logic force_ready,
	input logic [filter_pkg::NUM_FILTERS-1:0] pair_available,
	input filter_pkg::pair_rec_t [filter_pkg::NUM_FILTERS-1:0] heads,
	output logic [filter_pkg::NUM_FILTERS-1:0] sel,
	output filter_pkg::pair_rec_t pair_out,
	output filter_pkg::fid_t filter_id_out,
	output logic out_valid
);

	import filter_pkg::*;

	// Last filter served, the search starts one past it
	fid_t last_grant;
	fid_t grant_idx;
	logic grant_found;

	//////////////////////////////////////////////////////////////////////
	// Round-robin search
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		int cand;
		grant_found = 1'b0;
		grant_idx = last_grant;
		for (int i = 1; i <= NUM_FILTERS; i++)
		begin
			cand = (int'(last_grant) + i) % NUM_FILTERS;
			if (!grant_found && pair_available[cand])
			begin
				grant_found = 1'b1;
				grant_idx = fid_t'(cand);
			end
		end
	end

	// One-hot pop strobe, only while the force pipeline takes data
	always_comb
	begin
		sel = '0;
		if (force_ready && grant_found)
			sel[grant_idx] = 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			// First search after reset begins at filter 0
			last_grant <= fid_t'(NUM_FILTERS - 1);
		end
		else
		begin
			out_valid <= |sel;
			if (|sel)
				last_grant <= grant_idx;
		end
	end

	always_ff @(posedge clk)
	begin
		if (|sel)
		begin
			pair_out <= heads[grant_idx];
			filter_id_out <= grant_idx;
		end
	end

	// At most one pop per cycle, and only from a filter holding a pair
	a_sel_legal: assert property (@(posedge clk) disable iff (rst)
		$onehot0(sel) && ((sel & ~pair_available) == '0));

endmodule

`default_nettype wire

//--- src/filter_bank.sv
`default_nettype none

module filter_bank (
	input logic clk,
	input logic rst,
	input filter_pkg::pair_in_t [filter_pkg::NUM_FILTERS-1:0] pair_in,
	input logic [filter_pkg::NUM_FILTERS-1:0] in_valid,
	input logic force_ready,
	output filter_pkg::pair_rec_t pair_out,
	output filter_pkg::fid_t filter_id_out,
	output logic out_valid,
	output logic [filter_pkg::NUM_FILTERS-1:0] back_pressure
);

	import filter_pkg::*;

	// FIFO heads of every filter, seen by the arbiter
	pair_rec_t [NUM_FILTERS-1:0] heads;

	// Non-empty flags going up
	logic [NUM_FILTERS-1:0] pair_available;

	// Pop strobes coming down
	logic [NUM_FILTERS-1:0] sel;

	//////////////////////////////////////////////////////////////////////
	// Filters
	//////////////////////////////////////////////////////////////////////
	// Each filter owns its own input port and back-pressure level
	generate
		for (genvar f = 0; f < NUM_FILTERS; f++)
		begin : g_filter
			filter_logic u_filter (
				.clk(clk),
				.rst(rst),
				.in_valid(in_valid[f]),
				.pair_in(pair_in[f]),
				.sel(sel[f]),
				.head(heads[f]),
				.pair_available(pair_available[f]),
				.back_pressure(back_pressure[f])
			);
		end
	endgenerate

	//////////////////////////////////////////////////////////////////////
	// Arbiter and output stage
	//////////////////////////////////////////////////////////////////////
	// Shares the single force pipeline among all filters
	filter_arbiter u_arb (
		.clk(clk),
		.rst(rst),
		.force_ready(force_ready),
		.pair_available(pair_available),
		.heads(heads),
		.sel(sel),
		.pair_out(pair_out),
		.filter_id_out(filter_id_out),
		.out_valid(out_valid)
	);

endmodule

`default_nettype wire

//--- src/filter_buffer.sv
`default_nettype none

module filter_buffer (
	input logic clk,
	input logic rst,
	input logic wr_en,
	input filter_pkg::pair_rec_t wr_data,
	input logic rd_en,
	output filter_pkg::pair_rec_t rd_data,
	output logic empty,
	output logic [filter_pkg::BUF_ADDR_WIDTH:0] used
);

	import filter_pkg::*;

	// Storage, contents are don't-care until written
	pair_rec_t mem [BUF_DEPTH];

	// Pointers wrap naturally, depth is a power of two
	logic [BUF_ADDR_WIDTH-1:0] wr_ptr;
	logic [BUF_ADDR_WIDTH-1:0] rd_ptr;
	logic [BUF_ADDR_WIDTH:0] count;

	logic full;

	assign full = (count == (BUF_ADDR_WIDTH+1)'(BUF_DEPTH));
	assign empty = (count == '0);
	assign used = count;

	// Show-ahead read, head entry always on the output
	assign rd_data = mem[rd_ptr];

	//////////////////////////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
	end

	//////////////////////////////////////////////////////////////////////
	// Pointers and count
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop leaves the count alone
			case ({wr_en, rd_en})
				2'b10:
					count <= count + 1'b1;
				2'b01:
					count <= count - 1'b1;
				default:
					count <= count;
			endcase
		end
	end

	// Upstream back-pressure must keep the FIFO from overflowing
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> !full);

	// Arbiter only pops filters that report a pair
	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		rd_en |-> !empty);

endmodule

`default_nettype wire

//--- src/filter_logic.sv
`default_nettype none

module filter_logic (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input filter_pkg::pair_in_t pair_in,
	input logic sel,
	output filter_pkg::pair_rec_t head,
	output logic pair_available,
	output logic back_pressure
);

	import filter_pkg::*;

	// Particle IDs travel beside the r2 pipe
	typedef struct packed {
		pid_t ref_id;
		pid_t nbr_id;
	} id_pair_t;

	id_pair_t [R2_LATENCY-1:0] id_q;

	// r2_compute results
	delta_t dx;
	delta_t dy;
	delta_t dz;
	r2_t r2;
	logic r2_valid;

	// Registered write into the FIFO
	logic wr_en;
	pair_rec_t wr_data;

	// FIFO status
	logic buf_empty;
	logic [BUF_ADDR_WIDTH:0] used;
	logic [BUF_ADDR_WIDTH:0] free_slots;

	//////////////////////////////////////////////////////////////////////
	// Distance pipeline
	//////////////////////////////////////////////////////////////////////
	r2_compute u_r2 (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.ref_pos(pair_in.ref_pos),
		.nbr_pos(pair_in.nbr_pos),
		.dx(dx),
		.dy(dy),
		.dz(dz),
		.r2(r2),
		.r2_valid(r2_valid)
	);

	// ID delay chain, same depth as the r2 pipe
	always_ff @(posedge clk)
	begin
		id_q <= {id_q[R2_LATENCY-2:0], id_pair_t'{pair_in.ref_id, pair_in.nbr_id}};
	end

	//////////////////////////////////////////////////////////////////////
	// Cutoff compare and write stage
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
			wr_en <= 1'b0;
		else
			wr_en <= r2_valid && (r2 < CUTOFF_2);
	end

	// Record packed MSB to LSB as ref_id, nbr_id, r2, dz, dy, dx
	always_ff @(posedge clk)
	begin
		if (r2_valid)
			wr_data <= '{
				ref_id: id_q[R2_LATENCY-1].ref_id,
				nbr_id: id_q[R2_LATENCY-1].nbr_id,
				r2: r2,
				dz: dz,
				dy: dy,
				dx: dx
			};
	end

	filter_buffer u_buf (
		.clk(clk),
		.rst(rst),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.rd_en(sel),
		.rd_data(head),
		.empty(buf_empty),
		.used(used)
	);

	assign pair_available = !buf_empty;

	// Hold off the source while the free space could not absorb
	// the four pairs in r2_compute plus the one in the write stage
	assign free_slots = (BUF_ADDR_WIDTH+1)'(BUF_DEPTH) - used;
	assign back_pressure = (free_slots <= (BUF_ADDR_WIDTH+1)'(R2_LATENCY + 1));

endmodule

`default_nettype wire

//--- src/filter_pkg.sv
`default_nettype none

package filter_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sizing
	//////////////////////////////////////////////////////////////////////

	// Filters sharing one force pipeline
	localparam int NUM_FILTERS = 4;
	localparam int FID_WIDTH = 2;

	// Particle ID width
	localparam int PID_WIDTH = 12;

	// Q8.8 coordinates, displacement gains one bit for the subtraction
	localparam int COORD_WIDTH = 16;
	localparam int DELTA_WIDTH = 17;

	// Sum of three Q.16 squares, max 3 * 2^32 fits easily
	localparam int R2_WIDTH = 36;

	// Cycles from an accepted pair to r2_valid
	localparam int R2_LATENCY = 4;

	// 12.0 A cutoff squared, 144 in Q.16
	// A pair passes only when r2 is strictly below this
	localparam logic [R2_WIDTH-1:0] CUTOFF_2 = 144 * (1 << 16);

	// Survivor FIFO per filter
	localparam int BUF_DEPTH = 16;
	localparam int BUF_ADDR_WIDTH = 4;

	//////////////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////////////

	typedef logic [PID_WIDTH-1:0] pid_t;
	typedef logic signed [COORD_WIDTH-1:0] coord_t;
	typedef logic signed [DELTA_WIDTH-1:0] delta_t;
	typedef logic [R2_WIDTH-1:0] r2_t;
	typedef logic [FID_WIDTH-1:0] fid_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t z;
	} pos_t;

	// Candidate pair as it arrives from the pair generator
	typedef struct packed {
		pid_t ref_id;
		pid_t nbr_id;
		pos_t ref_pos;
		pos_t nbr_pos;
	} pair_in_t;

	// Filtered pair, displacements are neighbor minus reference
	typedef struct packed {
		pid_t ref_id;
		pid_t nbr_id;
		r2_t r2;
		delta_t dz;
		delta_t dy;
		delta_t dx;
	} pair_rec_t;

endpackage

`default_nettype wire

//--- src/r2_compute.sv
`default_nettype none

module r2_compute (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input filter_pkg::pos_t ref_pos,
	input filter_pkg::pos_t nbr_pos,
	output filter_pkg::delta_t dx,
	output filter_pkg::delta_t dy,
	output filter_pkg::delta_t dz,
	output filter_pkg::r2_t r2,
	output logic r2_valid
);

	import filter_pkg::*;

	// Displacement triple carried down the pipe
	typedef struct packed {
		delta_t dx;
		delta_t dy;
		delta_t dz;
	} disp_t;

	// Sign extend both sides by one bit, then subtract
	function automatic delta_t coord_diff(coord_t nbr, coord_t ref_c);
		return {nbr[COORD_WIDTH-1], nbr} - {ref_c[COORD_WIDTH-1], ref_c};
	endfunction

	// Square at full r2 width so nothing is lost
	function automatic r2_t square(delta_t d);
		logic signed [R2_WIDTH-1:0] w;
		w = {{(R2_WIDTH-DELTA_WIDTH){d[DELTA_WIDTH-1]}}, d};
		return w * w;
	endfunction

	disp_t [R2_LATENCY-1:0] disp_q;
	logic [R2_LATENCY-1:0] valid_q;

	// Stage 2 squares, stage 3 partial sum, stage 4 final sum
	r2_t sq_x;
	r2_t sq_y;
	r2_t sq_z;
	r2_t sum_xy;
	r2_t sq_z_d;
	r2_t r2_q;

	//////////////////////////////////////////////////////////////////////
	// Valid shift, one bit per stage
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
			valid_q <= '0;
		else
			valid_q <= {valid_q[R2_LATENCY-2:0], in_valid};
	end

	//////////////////////////////////////////////////////////////////////
	// Datapath, no reset needed on payload
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		// Stage 1 subtract
		disp_q[0] <= '{
			dx: coord_diff(nbr_pos.x, ref_pos.x),
			dy: coord_diff(nbr_pos.y, ref_pos.y),
			dz: coord_diff(nbr_pos.z, ref_pos.z)
		};
		// Displacements ride along with the arithmetic
		disp_q[R2_LATENCY-1:1] <= disp_q[R2_LATENCY-2:0];
		// Stage 2 square
		sq_x <= square(disp_q[0].dx);
		sq_y <= square(disp_q[0].dy);
		sq_z <= square(disp_q[0].dz);
		// Stage 3 add x and y, hold z
		sum_xy <= sq_x + sq_y;
		sq_z_d <= sq_z;
		// Stage 4 add z
		r2_q <= sum_xy + sq_z_d;
	end

	assign dx = disp_q[R2_LATENCY-1].dx;
	assign dy = disp_q[R2_LATENCY-1].dy;
	assign dz = disp_q[R2_LATENCY-1].dz;
	assign r2 = r2_q;
	assign r2_valid = valid_q[R2_LATENCY-1];

	// Every accepted pair yields a result exactly R2_LATENCY later
	a_latency: assert property (@(posedge clk) disable iff (rst)
		in_valid |-> ##R2_LATENCY r2_valid);

	// And no result appears without a matching input
	a_no_spurious: assert property (@(posedge clk) disable iff (rst)
		r2_valid |-> $past(in_valid, R2_LATENCY));

endmodule

`default_nettype wire

//--- tests/filter_bank_tb.sv
`default_nettype none

module filter_bank_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import filter_pkg::*;

	localparam int DRIVE_DELAY = 1;

	// Filters fed during the force_ready stall
	localparam logic [NUM_FILTERS-1:0] STALL_MASK = 4'b0011;

	// One row of the stimulus table
	typedef struct packed {
		logic [2:0] test;
		fid_t fid;
		logic idle;
		logic joined;
		logic ready;
		logic exp_pass;
		pair_in_t pair;
	} stim_t;

	logic clk;
	logic rst;
	pair_in_t [NUM_FILTERS-1:0] pair_in;
	logic [NUM_FILTERS-1:0] in_valid;
	logic force_ready;
	pair_rec_t pair_out;
	fid_t filter_id_out;
	logic out_valid;
	logic [NUM_FILTERS-1:0] back_pressure;

	int err_count;
	int out_count;
	int pred_count;
	int pending;

	stim_t stim_q[$];
	int exp_pass_count;
	int applied;
	int fault_count;
	int id_seq;
	logic [NUM_FILTERS-1:0] bp_seen;
	logic table_built;

	tb_clock u_clock (
		.clk(clk),
		.rst(rst)
	);

	filter_bank dut (
		.clk(clk),
		.rst(rst),
		.pair_in(pair_in),
		.in_valid(in_valid),
		.force_ready(force_ready),
		.pair_out(pair_out),
		.filter_id_out(filter_id_out),
		.out_valid(out_valid),
		.back_pressure(back_pressure)
	);

	filter_checker u_check (
		.clk(clk),
		.rst(rst),
		.pair_in(pair_in),
		.in_valid(in_valid),
		.out_valid(out_valid),
		.pair_out(pair_out),
		.filter_id_out(filter_id_out),
		.err_count(err_count),
		.out_count(out_count),
		.pred_count(pred_count),
		.pending(pending)
	);

	//////////////////////////////////////////////////////////////////////
	// Table building
	//////////////////////////////////////////////////////////////////////
	// Angstrom to Q8.8
	function automatic pos_t make_pos(real x, real y, real z);
		pos_t p;
		p.x = coord_t'($rtoi(x * 256.0));
		p.y = coord_t'($rtoi(y * 256.0));
		p.z = coord_t'($rtoi(z * 256.0));
		return p;
	endfunction

	// Within 4.0 of c on one axis so filler pairs always pass
	function automatic coord_t near(coord_t c);
		return coord_t'(int'($signed(c)) + int'($urandom_range(2047)) - 1024);
	endfunction

	task automatic add_pair(int test, int fid, int ref_id, int nbr_id, pos_t ref_pos,
		pos_t nbr_pos, logic ready, logic exp_pass, logic joined);
		stim_q.push_back(stim_t'{
			test: 3'(test),
			fid: fid_t'(fid),
			idle: 1'b0,
			joined: joined,
			ready: ready,
			exp_pass: exp_pass,
			pair: pair_in_t'{pid_t'(ref_id), pid_t'(nbr_id), ref_pos, nbr_pos}
		});
	endtask

	// One cycle with a random close pair on every filter in the mask
	task automatic add_filler_cycle(int test, logic [NUM_FILTERS-1:0] mask, logic ready);
		int last;
		pos_t r;
		pos_t n;
		last = 0;
		for (int f = 0; f < NUM_FILTERS; f++)
			if (mask[f])
				last = f;
		for (int f = 0; f < NUM_FILTERS; f++)
		begin
			if (mask[f])
			begin
				r.x = coord_t'(int'($urandom_range(32767)) - 16384);
				r.y = coord_t'(int'($urandom_range(32767)) - 16384);
				r.z = coord_t'(int'($urandom_range(32767)) - 16384);
				n.x = near(r.x);
				n.y = near(r.y);
				n.z = near(r.z);
				add_pair(test, f, id_seq, id_seq + 2048, r, n, ready, 1'b1, f != last);
				id_seq++;
			end
		end
	endtask

	// Cycles with no pair and only a force_ready level
	task automatic add_idle(int test, logic ready, int cycles);
		repeat (cycles)
		begin
			stim_q.push_back(stim_t'{
				test: 3'(test),
				fid: '0,
				idle: 1'b1,
				joined: 1'b0,
				ready: ready,
				exp_pass: 1'b0,
				pair: '0
			});
		end
	endtask

	task automatic build_table();
		// Inside the cutoff with negative displacements too
		add_pair(1, 0, 1, 2, make_pos(1.0, 2.0, 3.0), make_pos(4.0, 6.0, 3.0), 1, 1, 0);
		add_pair(1, 0, 3, 4, make_pos(10.0, -5.0, 0.5), make_pos(7.5, -9.25, -1.0), 1, 1, 0);
		add_pair(1, 1, 5, 6, make_pos(-100.0, 50.0, 20.0), make_pos(-104.0, 45.0, 16.0),
			1, 1, 0);
		add_pair(1, 2, 7, 8, make_pos(127.0, -128.0, 0.0), make_pos(120.0, -120.0, 0.0),
			1, 1, 0);
		add_pair(1, 3, 9, 10, make_pos(0.0, 0.0, 0.0), make_pos(0.00390625, -0.00390625, 0.0),
			1, 1, 0);
		// Pairs outside or exactly on the cutoff and a few just inside it
		add_pair(2, 0, 11, 12, make_pos(0.0, 0.0, 0.0), make_pos(12.0, 0.0, 0.0), 1, 0, 0);
		add_pair(2, 1, 13, 14, make_pos(5.0, 5.0, 5.0), make_pos(5.0, 5.0, -7.0), 1, 0, 0);
		add_pair(2, 2, 15, 16, make_pos(0.0, 0.0, 0.0), make_pos(11.99609375, 0.0, 0.0),
			1, 1, 0);
		add_pair(2, 3, 17, 18, make_pos(0.0, 0.0, 0.0), make_pos(8.0, 8.0, 8.0), 1, 0, 0);
		add_pair(2, 0, 19, 20, make_pos(-128.0, -128.0, -128.0),
			make_pos(127.99609375, 127.99609375, 127.99609375), 1, 0, 0);
		add_pair(2, 1, 21, 22, make_pos(1.0, 1.0, 1.0), make_pos(8.0, 8.0, 8.0), 1, 0, 0);
		add_pair(2, 2, 23, 24, make_pos(0.0, 0.0, 0.0), make_pos(-6.875, 6.875, -6.875),
			1, 1, 0);
		// All four filters fed in the same cycles
		repeat (8)
			add_filler_cycle(3, 4'b1111, 1'b1);
		// Long stall fills filters 0 and 1 before everything drains
		repeat (12)
			add_filler_cycle(4, STALL_MASK, 1'b0);
		add_idle(4, 1'b0, 6);
		repeat (6)
			add_filler_cycle(4, 4'b1111, 1'b1);
	endtask

	function automatic string test_label(int test);
		case (test)
			1: return "pairs inside the cutoff";
			2: return "pairs outside and on the cutoff";
			3: return "four filters at once";
			4: return "force_ready stall";
			default: return "unknown";
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Driving and per-test reports
	//////////////////////////////////////////////////////////////////////
	task automatic check_reset_state();
		if (out_valid !== 1'b0 || back_pressure !== '0)
		begin
			fault_count++;
			$display("mismatch at %0t: after reset out_valid=%b back_pressure=%b, expected 0",
				$time, out_valid, back_pressure);
		end
		repeat (3)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
			if (out_valid !== 1'b0)
			begin
				fault_count++;
				$display("mismatch at %0t: out_valid high with no pair applied", $time);
			end
		end
		$display("test 5, reset state: %0d errors", fault_count);
	endtask

	task automatic drain_and_report(int test, int errs_start);
		in_valid = '0;
		force_ready = 1'b1;
		// Pending reaches zero once every predicted pair came out
		while (pending != 0)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		// Quiet cycles catch late or duplicated outputs
		repeat (R2_LATENCY + 4)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		// Only the filters fed during the stall may raise back_pressure
		if (test == 4 && bp_seen !== STALL_MASK)
		begin
			fault_count++;
			$display("mismatch at %0t: back_pressure seen during the stall %b, expected %b",
				$time, bp_seen, STALL_MASK);
		end
		$display("test %0d, %s: %0d outputs so far, %0d errors", test, test_label(test),
			out_count, err_count + fault_count - errs_start);
	endtask

	task automatic apply_table();
		int i;
		int last;
		int cur_test;
		int errs_start;
		logic [NUM_FILTERS-1:0] mask;
		i = 0;
		errs_start = err_count + fault_count;
		while (i < stim_q.size())
		begin
			cur_test = stim_q[i].test;
			// Joined rows share one clock cycle
			last = i;
			while (stim_q[last].joined)
				last++;
			mask = '0;
			for (int k = i; k <= last; k++)
				if (!stim_q[k].idle)
					mask[stim_q[k].fid] = 1'b1;
			// Source held off while the force pipeline drains
			while ((back_pressure & mask) != '0)
			begin
				in_valid = '0;
				force_ready = 1'b1;
				@(posedge clk);
				#DRIVE_DELAY;
			end
			in_valid = '0;
			force_ready = stim_q[i].ready;
			for (int k = i; k <= last; k++)
			begin
				if (!stim_q[k].idle)
				begin
					pair_in[stim_q[k].fid] = stim_q[k].pair;
					in_valid[stim_q[k].fid] = 1'b1;
					applied++;
					if (stim_q[k].exp_pass)
						exp_pass_count++;
				end
			end
			@(posedge clk);
			#DRIVE_DELAY;
			if (!force_ready)
				bp_seen |= back_pressure;
			i = last + 1;
			if (i == stim_q.size() || stim_q[i].test != cur_test)
			begin
				drain_and_report(cur_test, errs_start);
				errs_start = err_count + fault_count;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		pair_in = '0;
		in_valid = '0;
		force_ready = 1'b0;
		exp_pass_count = 0;
		applied = 0;
		fault_count = 0;
		id_seq = 100;
		bp_seen = '0;
		table_built = 1'b0;
		void'($urandom(32'h7966));
		build_table();
		table_built = 1'b1;
		wait (rst === 1'b0);
		check_reset_state();
		apply_table();
		// Every passing pair comes out exactly once and nothing else does
		if (out_count != exp_pass_count || out_count != pred_count)
		begin
			fault_count++;
			$display("mismatch at %0t: %0d outputs, table expects %0d, checker predicted %0d",
				$time, out_count, exp_pass_count, pred_count);
		end
		$display("summary: %0d pairs applied, %0d expected out, %0d out, %0d errors",
			applied, exp_pass_count, out_count, err_count + fault_count);
		if (err_count == 0 && fault_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Forty cycles per table row is far more than any row needs
	initial
	begin
		wait (table_built);
		repeat (stim_q.size() * 40) @(posedge clk);
		$display("timeout: the run did not finish within %0d clock cycles",
			stim_q.size() * 40);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/filter_checker.sv
`default_nettype none

module filter_checker (
	input logic clk,
	input logic rst,
	input filter_pkg::pair_in_t [filter_pkg::NUM_FILTERS-1:0] pair_in,
	input logic [filter_pkg::NUM_FILTERS-1:0] in_valid,
	input logic out_valid,
	input filter_pkg::pair_rec_t pair_out,
	input filter_pkg::fid_t filter_id_out,
	output int err_count,
	output int out_count,
	output int pred_count,
	output int pending
);

	timeunit 1ns;
	timeprecision 100ps;

	import filter_pkg::*;

	// 12.0 squared in Q.16
	localparam longint CUTOFF_Q16 = 144 * 65536;

	// One queue of expected records per filter in input order
	pair_rec_t exp_q [NUM_FILTERS][$];

	// Record built straight from the geometry as neighbor minus reference
	function automatic pair_rec_t predict(pair_in_t p);
		int ex;
		int ey;
		int ez;
		pair_rec_t rec;
		ex = int'($signed(p.nbr_pos.x)) - int'($signed(p.ref_pos.x));
		ey = int'($signed(p.nbr_pos.y)) - int'($signed(p.ref_pos.y));
		ez = int'($signed(p.nbr_pos.z)) - int'($signed(p.ref_pos.z));
		rec.ref_id = p.ref_id;
		rec.nbr_id = p.nbr_id;
		rec.dx = delta_t'(ex);
		rec.dy = delta_t'(ey);
		rec.dz = delta_t'(ez);
		rec.r2 = r2_t'(longint'(ex) * ex + longint'(ey) * ey + longint'(ez) * ez);
		return rec;
	endfunction

	// Expected record and the one that came out, on a single line
	task automatic report_mismatch(fid_t fid, pair_rec_t exp_rec, pair_rec_t got);
		$write("mismatch at %0t: filter %0d expected ids %0d/%0d d=(%0d,%0d,%0d) r2=%0d",
			$time, fid, exp_rec.ref_id, exp_rec.nbr_id,
			exp_rec.dx, exp_rec.dy, exp_rec.dz, exp_rec.r2);
		$display(", got ids %0d/%0d d=(%0d,%0d,%0d) r2=%0d",
			got.ref_id, got.nbr_id, got.dx, got.dy, got.dz, got.r2);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare outputs, then queue new predictions
	//////////////////////////////////////////////////////////////////////
	// Sampled on the edge so both sides show their pre-edge values
	always @(posedge clk)
	begin
		pair_rec_t rec;
		pair_rec_t exp_rec;
		if (!rst)
		begin
			if (out_valid)
			begin
				out_count++;
				if (exp_q[filter_id_out].size() == 0)
				begin
					err_count++;
					$display("output from filter %0d at %0t with no pair waiting for it",
						filter_id_out, $time);
				end
				else
				begin
					exp_rec = exp_q[filter_id_out].pop_front();
					if (pair_out !== exp_rec)
					begin
						err_count++;
						report_mismatch(filter_id_out, exp_rec, pair_out);
					end
				end
			end
			// Only pairs strictly inside the cutoff are expected out
			for (int f = 0; f < NUM_FILTERS; f++)
			begin
				if (in_valid[f])
				begin
					rec = predict(pair_in[f]);
					if (longint'(rec.r2) < CUTOFF_Q16)
					begin
						exp_q[f].push_back(rec);
						pred_count++;
					end
				end
			end
		end
		pending = 0;
		for (int f = 0; f < NUM_FILTERS; f++)
			pending += exp_q[f].size();
	end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	// 40 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// Reset held over two rising edges, released just after the second
	initial
	begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
	end

endmodule

`default_nettype wire
